/* wb_pkg.sv */
package wb_pkg;

    // data word for instructions, pcs, write data and cp0 values
    typedef logic [31:0] word_t;

    // register file index
    typedef logic [4:0] reg_addr_t;

    localparam int NUM_REGS = 32;

    // one instruction moving from memory to writeback
    typedef struct packed {
        logic      valid;
        logic      reg_wen;
        reg_addr_t reg_waddr;
        word_t     inst;
        word_t     pc;
        word_t     reg_wdata;
    } lane_t;

    // cp0 debug values, master lane only
    typedef struct packed {
        word_t cp0_count;
        word_t cp0_random;
        word_t cp0_cause;
        logic  int_pending;
    } dbg_t;

    // writeback stage controller states
    typedef enum logic [1:0] {
        st_run,
        st_stall,
        st_flush
    } ctrl_state_t;

    // debug port word addresses above the register window
    localparam logic [5:0] DBG_ADDR_RETIRED = 6'd32;
    localparam logic [5:0] DBG_ADDR_CYCLES  = 6'd33;

endpackage

/* wb_stage_ctrl.sv */
`timescale 1ns/1ps

module wb_stage_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic stall,
    input  logic except_master,
    input  logic except_slave,
    output logic clear_master,
    output logic clear_slave,
    output logic ena_master,
    output logic ena_slave
);
    import wb_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_run;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        clear_master = 1'b0;
        clear_slave  = 1'b0;
        ena_master   = 1'b1;
        ena_slave    = 1'b1;
        state_next   = state;

        case (state)
            st_flush: begin
                // squash the wrong-path pair behind the exception
                clear_master = 1'b1;
                clear_slave  = 1'b1;
                state_next   = st_run;
            end
            default: begin
                // st_run and st_stall share the request priority
                if (except_master) begin
                    clear_master = 1'b1;
                    clear_slave  = 1'b1;
                    state_next   = st_flush;
                end else if (except_slave) begin
                    // master is older, so it still retires
                    clear_slave  = 1'b1;
                    state_next   = st_flush;
                end else if (stall) begin
                    ena_master   = 1'b0;
                    ena_slave    = 1'b0;
                    state_next   = st_stall;
                end else begin
                    state_next   = st_run;
                end
            end
        endcase
    end

    // a flush always hands control back to st_run, never straight to a stall
    a_flush_returns_to_run: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == st_flush && clear_master) |=> (state == st_run));

endmodule

/* mem_wb.sv */
`timescale 1ns/1ps

module mem_wb (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          clear_master,
    input  logic          clear_slave,
    input  logic          ena_master,
    input  logic          ena_slave,
    input  wb_pkg::lane_t m_master,
    input  wb_pkg::lane_t m_slave,
    input  wb_pkg::dbg_t  m_dbg,
    output wb_pkg::lane_t w_master,
    output wb_pkg::lane_t w_slave,
    output wb_pkg::dbg_t  w_dbg
);
    import wb_pkg::*;

    lane_t master_q;
    lane_t slave_q;
    dbg_t  dbg_q;

    // high only in the cycle right after a load
    logic fresh_master;
    logic fresh_slave;

    // master lane carries the cp0 debug values along
    always_ff @(posedge clk) begin
        if (!rst_n || clear_master) begin
            master_q     <= '0;
            dbg_q        <= '0;
            fresh_master <= 1'b0;
        end else if (ena_master) begin
            master_q     <= m_master;
            dbg_q        <= m_dbg;
            fresh_master <= 1'b1;
        end else begin
            fresh_master <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || clear_slave) begin
            slave_q     <= '0;
            fresh_slave <= 1'b0;
        end else if (ena_slave) begin
            slave_q     <= m_slave;
            fresh_slave <= 1'b1;
        end else begin
            fresh_slave <= 1'b0;
        end
    end

    // held entries keep their contents but read as not valid
    always_comb begin
        w_master       = master_q;
        w_master.valid = master_q.valid & fresh_master;
        w_slave        = slave_q;
        w_slave.valid  = slave_q.valid & fresh_slave;
    end

    assign w_dbg = dbg_q;

    a_clear_master_kills_valid: assert property (
        @(posedge clk) disable iff (!rst_n) clear_master |=> !w_master.valid);

    a_clear_slave_kills_valid: assert property (
        @(posedge clk) disable iff (!rst_n) clear_slave |=> !w_slave.valid);

endmodule

/* wb_regfile.sv */
`timescale 1ns/1ps

module wb_regfile (
    input  logic              clk,
    input  logic              rst_n,
    input  wb_pkg::lane_t     w_master,
    input  wb_pkg::lane_t     w_slave,
    input  wb_pkg::reg_addr_t rd_addr,
    output wb_pkg::word_t     rd_data
);
    import wb_pkg::*;

    word_t regs [NUM_REGS];

    logic master_we;
    logic slave_we;

    // register 0 is hardwired, never take a write to it
    assign master_we = w_master.valid && w_master.reg_wen && (w_master.reg_waddr != '0);
    assign slave_we  = w_slave.valid && w_slave.reg_wen && (w_slave.reg_waddr != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (master_we) begin
                regs[w_master.reg_waddr] <= w_master.reg_wdata;
            end
            // slave is later in program order, so it wins on the same index
            if (slave_we) begin
                regs[w_slave.reg_waddr] <= w_slave.reg_wdata;
            end
        end
    end

    assign rd_data = regs[rd_addr];

endmodule

/* retire_counter.sv */
`timescale 1ns/1ps

module retire_counter (
    input  logic          clk,
    input  logic          rst_n,
    input  wb_pkg::lane_t w_master,
    input  wb_pkg::lane_t w_slave,
    output wb_pkg::word_t retired,
    output wb_pkg::word_t cycles
);
    import wb_pkg::*;

    word_t retire_inc;

    // zero, one or two lanes retire per edge
    assign retire_inc = word_t'(w_master.valid) + word_t'(w_slave.valid);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retired <= '0;
        end else begin
            retired <= retired + retire_inc;
        end
    end

    // free running, wraps at 32 bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cycles <= '0;
        end else begin
            cycles <= cycles + word_t'(1);
        end
    end

endmodule

/* wb_debug_port.sv */
`timescale 1ns/1ps

module wb_debug_port (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  logic [5:0]        wb_adr,
    output wb_pkg::word_t     wb_dat_o,
    output logic              wb_ack,
    output wb_pkg::reg_addr_t rd_addr,
    input  wb_pkg::word_t     rd_data,
    input  wb_pkg::word_t     retired,
    input  wb_pkg::word_t     cycles
);
    import wb_pkg::*;

    logic  req;
    word_t sel_data;

    // no new request in the ack cycle, stb is still up there
    assign req     = wb_cyc && wb_stb && !wb_ack;
    assign rd_addr = wb_adr[4:0];

    always_comb begin
        if (wb_we) begin
            sel_data = '0;
        end else if (!wb_adr[5]) begin
            sel_data = rd_data;
        end else if (wb_adr == DBG_ADDR_RETIRED) begin
            sel_data = retired;
        end else if (wb_adr == DBG_ADDR_CYCLES) begin
            sel_data = cycles;
        end else begin
            sel_data = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            wb_dat_o <= sel_data;
        end
    end

    a_ack_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) wb_ack |=> !wb_ack);

endmodule

/* wb_subsys_top.sv */
`timescale 1ns/1ps

module wb_subsys_top (
    input  logic          clk,
    input  logic          rst_n,
    input  wb_pkg::lane_t m_master,
    input  wb_pkg::lane_t m_slave,
    input  wb_pkg::dbg_t  m_dbg,
    input  logic          stall,
    input  logic          except_master,
    input  logic          except_slave,
    output wb_pkg::lane_t w_master,
    output wb_pkg::lane_t w_slave,
    output wb_pkg::dbg_t  w_dbg,
    input  logic          wb_cyc,
    input  logic          wb_stb,
    input  logic          wb_we,
    input  logic [5:0]    wb_adr,
    output wb_pkg::word_t wb_dat_o,
    output logic          wb_ack
);
    import wb_pkg::*;

    logic clear_master;
    logic clear_slave;
    logic ena_master;
    logic ena_slave;

    reg_addr_t rd_addr;
    word_t     rd_data;
    word_t     retired;
    word_t     cycles;

    wb_stage_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (stall),
        .except_master (except_master),
        .except_slave  (except_slave),
        .clear_master  (clear_master),
        .clear_slave   (clear_slave),
        .ena_master    (ena_master),
        .ena_slave     (ena_slave)
    );

    mem_wb u_mem_wb (
        .clk          (clk),
        .rst_n        (rst_n),
        .clear_master (clear_master),
        .clear_slave  (clear_slave),
        .ena_master   (ena_master),
        .ena_slave    (ena_slave),
        .m_master     (m_master),
        .m_slave      (m_slave),
        .m_dbg        (m_dbg),
        .w_master     (w_master),
        .w_slave      (w_slave),
        .w_dbg        (w_dbg)
    );

    wb_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .w_master (w_master),
        .w_slave  (w_slave),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    retire_counter u_counter (
        .clk      (clk),
        .rst_n    (rst_n),
        .w_master (w_master),
        .w_slave  (w_slave),
        .retired  (retired),
        .cycles   (cycles)
    );

    wb_debug_port u_debug (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .retired  (retired),
        .cycles   (cycles)
    );

endmodule

/* tb_wb_subsys.sv */
`timescale 1ns/1ps

module tb_wb_subsys;
    import wb_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int NUM_FIXED   = 21;
    localparam int NUM_RAND    = 8;
    localparam int NUM_READS   = 38;
    localparam int WATCHDOG_NS = (NUM_FIXED + NUM_RAND + NUM_READS) * 10 * CLK_PERIOD;

    typedef struct packed {
        lane_t      m;
        lane_t      s;
        dbg_t       d;
        logic [2:0] ctl;   // stall, except_master, except_slave
        logic [1:0] exp_v; // expected w valid bits, master then slave
    } row_t;

    logic       clk;
    logic       rst_n;
    lane_t      m_master;
    lane_t      m_slave;
    dbg_t       m_dbg;
    logic       stall;
    logic       except_master;
    logic       except_slave;
    lane_t      w_master;
    lane_t      w_slave;
    dbg_t       w_dbg;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    logic [5:0] wb_adr;
    word_t      wb_dat_o;
    logic       wb_ack;

    row_t  rows[$];
    word_t pc_next;
    word_t rng_state;
    int    errors;
    int    reads;

    // reference model state
    ctrl_state_t model_state;
    lane_t       mq_m;
    lane_t       mq_s;
    dbg_t        mq_d;
    logic        mf_m;
    logic        mf_s;
    word_t       model_regs [NUM_REGS];
    word_t       model_retired;

    wb_subsys_top uut (
        .clk           (clk),
        .rst_n         (rst_n),
        .m_master      (m_master),
        .m_slave       (m_slave),
        .m_dbg         (m_dbg),
        .stall         (stall),
        .except_master (except_master),
        .except_slave  (except_slave),
        .w_master      (w_master),
        .w_slave       (w_slave),
        .w_dbg         (w_dbg),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_dat_o      (wb_dat_o),
        .wb_ack        (wb_ack)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic word_t next_random(input word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic lane_t make_lane(input logic v, input logic wen, input reg_addr_t a,
                                        input word_t data);
        lane_t l;
        l.valid     = v;
        l.reg_wen   = wen;
        l.reg_waddr = a;
        l.inst      = 32'h2400_0000 | {11'd0, a, 16'd0};
        l.pc        = pc_next;
        l.reg_wdata = data;
        pc_next     = pc_next + 32'd4;
        return l;
    endfunction

    task automatic add_row(input lane_t m, input lane_t s, input logic [2:0] ctl,
                           input logic [1:0] exp_v);
        row_t r;
        r.m                = m;
        r.s                = s;
        r.ctl              = ctl;
        r.exp_v            = exp_v;
        r.d.cp0_count      = 32'h0001_0000 + rows.size();
        r.d.cp0_random     = 32'h0000_001f - rows.size();
        r.d.cp0_cause      = rows.size() << 10;
        r.d.int_pending    = rows.size() % 2;
        rows.push_back(r);
    endtask

    task automatic add_pair(input reg_addr_t ma, input word_t md, input reg_addr_t sa,
                            input word_t sd, input logic [2:0] ctl, input logic [1:0] exp_v);
        add_row(make_lane(1'b1, 1'b1, ma, md), make_lane(1'b1, 1'b1, sa, sd), ctl, exp_v);
    endtask

    task automatic build_rows();
        reg_addr_t ma;
        reg_addr_t sa;
        word_t     md;
        add_pair(5'd1, 32'h1111_1111, 5'd2, 32'h2222_2222, 3'b000, 2'b11);
        add_pair(5'd3, 32'h3333_3333, 5'd4, 32'h4444_4444, 3'b000, 2'b11);
        // stalled pairs carry bad data, they must never land
        add_pair(5'd5, 32'hbad0_0005, 5'd6, 32'hbad0_0006, 3'b100, 2'b00);
        add_pair(5'd7, 32'hbad0_0007, 5'd8, 32'hbad0_0008, 3'b100, 2'b00);
        add_pair(5'd5, 32'hbad1_0005, 5'd6, 32'hbad1_0006, 3'b100, 2'b00);
        add_pair(5'd5, 32'h5555_5555, 5'd6, 32'h6666_6666, 3'b000, 2'b11);
        add_pair(5'd7, 32'h7777_7777, 5'd8, 32'hdead_0008, 3'b001, 2'b10);
        add_pair(5'd9, 32'hdead_0009, 5'd10, 32'hdead_000a, 3'b000, 2'b00);
        add_pair(5'd11, 32'hbbbb_bbbb, 5'd12, 32'hcccc_cccc, 3'b000, 2'b11);
        add_pair(5'd13, 32'hdead_000d, 5'd14, 32'hdead_000e, 3'b010, 2'b00);
        add_pair(5'd15, 32'hdead_000f, 5'd16, 32'hdead_0010, 3'b000, 2'b00);
        // same target on both lanes
        add_pair(5'd17, 32'h0000_aaaa, 5'd17, 32'h0000_5555, 3'b000, 2'b11);
        add_pair(5'd0, 32'h0bad_0000, 5'd0, 32'h0bad_0001, 3'b000, 2'b11);
        add_row(make_lane(1'b1, 1'b1, 5'd18, 32'h1818_1818),
                make_lane(1'b0, 1'b1, 5'd22, 32'hdead_0016), 3'b000, 2'b10);
        // exception wins over a stall in the same cycle
        add_pair(5'd19, 32'h1919_1919, 5'd23, 32'hdead_0017, 3'b101, 2'b10);
        add_pair(5'd24, 32'hdead_0018, 5'd25, 32'hdead_0019, 3'b100, 2'b00);
        add_pair(5'd24, 32'hdead_1018, 5'd25, 32'hdead_1019, 3'b100, 2'b00);
        add_pair(5'd26, 32'hdead_001a, 5'd27, 32'hdead_001b, 3'b110, 2'b00);
        add_pair(5'd28, 32'hdead_001c, 5'd29, 32'hdead_001d, 3'b000, 2'b00);
        add_row(make_lane(1'b1, 1'b0, 5'd20, 32'hdead_0014),
                make_lane(1'b1, 1'b1, 5'd21, 32'h2121_2121), 3'b000, 2'b11);
        for (int i = 0; i < NUM_RAND; i++) begin
            rng_state = next_random(rng_state);
            ma        = rng_state[4:0];
            md        = rng_state;
            rng_state = next_random(rng_state);
            sa        = rng_state[9:5];
            add_pair(ma, md, sa, rng_state, 3'b000, 2'b11);
        end
        // empty pair so the last writes reach the register file
        add_row('0, '0, 3'b000, 2'b00);
    endtask

    task automatic report_value(input string name, input logic [127:0] got,
                                input logic [127:0] exp);
        errors++;
        $display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
    endtask

    task automatic commit_lane(input lane_t l);
        if (l.valid) begin
            model_retired = model_retired + 32'd1;
            if (l.reg_wen && l.reg_waddr != 5'd0) begin
                model_regs[l.reg_waddr] = l.reg_wdata;
            end
        end
    endtask

    task automatic apply_row(input row_t r);
        logic  clr_m;
        logic  clr_s;
        logic  ena;
        lane_t exp_m;
        lane_t exp_s;
        m_master = r.m;
        m_slave  = r.s;
        m_dbg    = r.d;
        {stall, except_master, except_slave} = r.ctl;
        clr_m = 1'b0;
        clr_s = 1'b0;
        ena   = 1'b1;
        if (model_state == st_flush) begin
            clr_m       = 1'b1;
            clr_s       = 1'b1;
            model_state = st_run;
        end else if (r.ctl[1]) begin
            clr_m       = 1'b1;
            clr_s       = 1'b1;
            model_state = st_flush;
        end else if (r.ctl[0]) begin
            clr_s       = 1'b1;
            model_state = st_flush;
        end else if (r.ctl[2]) begin
            ena         = 1'b0;
            model_state = st_stall;
        end else begin
            model_state = st_run;
        end
        if (clr_m) begin
            mq_m = '0;
            mq_d = '0;
            mf_m = 1'b0;
        end else if (ena) begin
            mq_m = r.m;
            mq_d = r.d;
            mf_m = 1'b1;
        end else begin
            mf_m = 1'b0;
        end
        if (clr_s) begin
            mq_s = '0;
            mf_s = 1'b0;
        end else if (ena) begin
            mq_s = r.s;
            mf_s = 1'b1;
        end else begin
            mf_s = 1'b0;
        end
        exp_m       = mq_m;
        exp_m.valid = mq_m.valid & mf_m;
        exp_s       = mq_s;
        exp_s.valid = mq_s.valid & mf_s;
        @(posedge clk);
        #1;
        if ({w_master.valid, w_slave.valid} !== r.exp_v) begin
            report_value("w valid bits", {w_master.valid, w_slave.valid}, r.exp_v);
        end
        if (w_master !== exp_m) begin
            report_value("w_master", w_master, exp_m);
        end
        if (w_slave !== exp_s) begin
            report_value("w_slave", w_slave, exp_s);
        end
        if (w_dbg !== mq_d) begin
            report_value("w_dbg", w_dbg, mq_d);
        end
        // master first, the later slave overwrites on the same index
        commit_lane(exp_m);
        commit_lane(exp_s);
    endtask

    // one classic bus cycle, called and left at 1 ns after a rising edge
    task automatic wb_cycle(input logic we, input logic [5:0] adr, output word_t data);
        int waited;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = we;
        wb_adr = adr;
        @(posedge clk);
        #1;
        waited = 1;
        while (!wb_ack && waited < 4) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!wb_ack) begin
            errors++;
            $display("debug port never acknowledged the cycle to address %0d", adr);
        end
        data   = wb_dat_o;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(posedge clk);
        #1;
        if (wb_ack) begin
            errors++;
            $display("ack stayed high longer than one cycle at address %0d", adr);
        end
        reads++;
    endtask

    task automatic check_read(input logic [5:0] adr, input word_t exp);
        word_t got;
        wb_cycle(1'b0, adr, got);
        if (got !== exp) begin
            report_value($sformatf("wb_dat_o at address %0d", adr), got, exp);
        end
    endtask

    initial begin
        word_t scratch;
        word_t cyc_a;
        word_t cyc_b;
        clk           = 1'b0;
        rst_n         = 1'b0;
        m_master      = '0;
        m_slave       = '0;
        m_dbg         = '0;
        stall         = 1'b0;
        except_master = 1'b0;
        except_slave  = 1'b0;
        wb_cyc        = 1'b0;
        wb_stb        = 1'b0;
        wb_we         = 1'b0;
        wb_adr        = '0;
        errors        = 0;
        reads         = 0;
        pc_next       = 32'h0040_0000;
        rng_state     = 32'h7c1;
        model_state   = st_run;
        mq_m          = '0;
        mq_s          = '0;
        mq_d          = '0;
        mf_m          = 1'b0;
        mf_s          = 1'b0;
        model_retired = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        build_rows();

        repeat (8) @(posedge clk);
        #1;
        if (w_master !== '0) begin
            report_value("w_master after reset", w_master, '0);
        end
        if (w_slave !== '0) begin
            report_value("w_slave after reset", w_slave, '0);
        end
        if (w_dbg !== '0) begin
            report_value("w_dbg after reset", w_dbg, '0);
        end
        if (wb_ack !== 1'b0) begin
            report_value("wb_ack after reset", wb_ack, 1'b0);
        end
        rst_n = 1'b1;

        foreach (rows[i]) begin
            apply_row(rows[i]);
        end

        for (int i = 0; i < NUM_REGS; i++) begin
            check_read(6'(i), model_regs[i]);
        end
        check_read(DBG_ADDR_RETIRED, model_retired);
        check_read(6'd45, '0);
        // a write is acknowledged but leaves the register alone
        wb_cycle(1'b1, 6'd5, scratch);
        check_read(6'd5, model_regs[5]);

        // request edges seven clocks apart
        wb_cycle(1'b0, DBG_ADDR_CYCLES, cyc_a);
        repeat (5) @(posedge clk);
        #1;
        wb_cycle(1'b0, DBG_ADDR_CYCLES, cyc_b);
        if (cyc_b - cyc_a !== 32'd7) begin
            report_value("cycle count difference", cyc_b - cyc_a, 32'd7);
        end

        $display("%0d rows applied, %0d debug cycles, %0d errors", rows.size(), reads, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // bounded by the number of rows and debug cycles
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        $display("%0d rows applied, %0d debug cycles, %0d errors", rows.size(), reads, errors);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* list.f */
wb_pkg.sv
wb_stage_ctrl.sv
mem_wb.sv
wb_regfile.sv
retire_counter.sv
wb_debug_port.sv
wb_subsys_top.sv
tb_wb_subsys.sv

/* Bender.yml */
package:
  name: wb_subsys

sources:
  - wb_pkg.sv
  - wb_stage_ctrl.sv
  - mem_wb.sv
  - wb_regfile.sv
  - retire_counter.sv
  - wb_debug_port.sv
  - wb_subsys_top.sv
  - target: simulation
    files:
      - tb_wb_subsys.sv
